// ==== logic/conv_cfg_pkg.sv ====
`default_nettype none

package conv_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Array and chunk shape
  ////////////////////////////////////////////////////////////

  // Output features per row group
  localparam int unsigned PE_ROWS = 8;
  localparam int unsigned PE_ROWS_LOG2 = $clog2(PE_ROWS);

  // Weight words consumed by one input chunk
  localparam int unsigned CHUNK_WORDS = 64;
  localparam int unsigned CHUNK_WORDS_LOG2 = $clog2(CHUNK_WORDS);

  // DDR word strides from one chunk to the next
  localparam int unsigned WEIGHT_CHUNK_WORDS = 64;
  localparam int unsigned INPUT_CHUNK_WORDS = 32;

  ////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////

  localparam int unsigned FEAT_W = 16;
  localparam int unsigned KERNEL_W = 4;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned INSTR_W = 2 * FEAT_W + KERNEL_W + 2 * ADDR_W;

  // Field offsets, of sits in the top bits
  localparam int unsigned IBASE_LSB = 0;
  localparam int unsigned WBASE_LSB = IBASE_LSB + ADDR_W;
  localparam int unsigned K_LSB = WBASE_LSB + ADDR_W;
  localparam int unsigned NIF_LSB = K_LSB + KERNEL_W;
  localparam int unsigned OF_LSB = NIF_LSB + FEAT_W;

endpackage

`default_nettype wire

// ==== logic/conv_ctrl_pkg.sv ====
`default_nettype none

package conv_ctrl_pkg;

  // Loop index widths
  localparam int unsigned CHUNK_W = 16;
  localparam int unsigned GROUP_W = 8;

  // Layer phases
  typedef enum logic [3:0] {
    IDLE,
    LOAD_W,
    WAIT_W,
    LOAD_I,
    WAIT_I,
    COMPUTE,
    WAIT_C,
    STORE,
    WAIT_S,
    DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/conv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_decoder (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              conv_decode,
  input  logic [conv_cfg_pkg::INSTR_W-1:0]  instr,
  input  logic                              busy,
  output logic                              conv_start,
  output logic [conv_ctrl_pkg::CHUNK_W-1:0] n_chunks,
  output logic [conv_ctrl_pkg::GROUP_W-1:0] n_groups,
  output logic [conv_cfg_pkg::ADDR_W-1:0]   weights_base,
  output logic [conv_cfg_pkg::ADDR_W-1:0]   input_base
);

  localparam int unsigned FW = conv_cfg_pkg::FEAT_W;
  localparam int unsigned KW = conv_cfg_pkg::KERNEL_W;
  localparam int unsigned AW = conv_cfg_pkg::ADDR_W;
  localparam int unsigned PW = FW + 2 * KW;

  logic          accept;
  logic [FW-1:0] of_q;
  logic [FW-1:0] nif_q;
  logic [KW-1:0] k_q;
  logic [FW:0]   of_round;
  logic [FW:0]   groups_full;
  logic [PW-1:0] nif_kk;
  logic [PW:0]   kk_round;
  logic [PW:0]   chunks_full;

  // Busy only rises the cycle after conv_start
  assign accept = conv_decode && !busy && !conv_start;

  always_ff @(posedge clk) begin
    if (reset) begin
      conv_start <= 1'b0;
    end else begin
      conv_start <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      of_q         <= instr[conv_cfg_pkg::OF_LSB +: FW];
      nif_q        <= instr[conv_cfg_pkg::NIF_LSB +: FW];
      k_q          <= instr[conv_cfg_pkg::K_LSB +: KW];
      weights_base <= instr[conv_cfg_pkg::WBASE_LSB +: AW];
      input_base   <= instr[conv_cfg_pkg::IBASE_LSB +: AW];
    end
  end

  ////////////////////////////////////////////////////////////
  // Loop bounds
  ////////////////////////////////////////////////////////////

  // ceil(of / PE_ROWS)
  assign of_round    = {1'b0, of_q} + (FW + 1)'(conv_cfg_pkg::PE_ROWS - 1);
  assign groups_full = of_round >> conv_cfg_pkg::PE_ROWS_LOG2;
  assign n_groups    = groups_full[conv_ctrl_pkg::GROUP_W-1:0];

  // ceil(nif * k * k / CHUNK_WORDS)
  assign nif_kk      = nif_q * k_q * k_q;
  assign kk_round    = {1'b0, nif_kk} + (PW + 1)'(conv_cfg_pkg::CHUNK_WORDS - 1);
  assign chunks_full = kk_round >> conv_cfg_pkg::CHUNK_WORDS_LOG2;
  assign n_chunks    = chunks_full[conv_ctrl_pkg::CHUNK_W-1:0];

  // An empty layer would leave the controller with no chunk to run
  a_shape_nonzero: assert property (
    @(posedge clk) disable iff (reset)
    conv_start |-> (k_q != '0) && (nif_q != '0)
  ) else $error("conv_decoder: layer started with k or nif of zero");

endmodule

`default_nettype wire

// ==== logic/conv_loop_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_loop_counter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              conv_start,
  input  logic                              next_chunk,
  input  logic                              next_group,
  input  logic [conv_ctrl_pkg::CHUNK_W-1:0] n_chunks,
  input  logic [conv_ctrl_pkg::GROUP_W-1:0] n_groups,
  output logic [conv_ctrl_pkg::CHUNK_W-1:0] chunk_idx,
  output logic [conv_ctrl_pkg::GROUP_W-1:0] group_idx,
  output logic                              chunk_last,
  output logic                              group_last
);

  localparam int unsigned CW = conv_ctrl_pkg::CHUNK_W;
  localparam int unsigned GW = conv_ctrl_pkg::GROUP_W;

  logic [CW-1:0] chunk_top;
  logic [GW-1:0] group_top;

  always_ff @(posedge clk) begin
    if (reset) begin
      chunk_idx <= '0;
      group_idx <= '0;
    end else if (conv_start) begin
      chunk_idx <= '0;
      group_idx <= '0;
    end else if (next_group) begin
      // New row group restarts the chunk walk
      chunk_idx <= '0;
      group_idx <= group_idx + 1'b1;
    end else if (next_chunk) begin
      chunk_idx <= chunk_idx + 1'b1;
    end
  end

  assign chunk_top  = n_chunks - 1'b1;
  assign group_top  = n_groups - 1'b1;
  assign chunk_last = (chunk_idx == chunk_top);
  assign group_last = (group_idx == group_top);

  // Controller advances either the chunk or the group, never both
  a_single_advance: assert property (
    @(posedge clk) disable iff (reset)
    !(next_chunk && next_group)
  ) else $error("conv_loop_counter: next_chunk and next_group together");

endmodule

`default_nettype wire

// ==== logic/conv_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_addr_gen (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            conv_start,
  input  logic                            next_chunk,
  input  logic                            next_group,
  input  logic [conv_cfg_pkg::ADDR_W-1:0] weights_base,
  input  logic [conv_cfg_pkg::ADDR_W-1:0] input_base,
  output logic [conv_cfg_pkg::ADDR_W-1:0] weights_addr,
  output logic [conv_cfg_pkg::ADDR_W-1:0] input_addr
);

  localparam int unsigned AW = conv_cfg_pkg::ADDR_W;
  localparam logic [AW-1:0] W_STEP = AW'(conv_cfg_pkg::WEIGHT_CHUNK_WORDS);
  localparam logic [AW-1:0] I_STEP = AW'(conv_cfg_pkg::INPUT_CHUNK_WORDS);

  logic advance;

  assign advance = next_chunk || next_group;

  ////////////////////////////////////////////////////////////
  // Weight address
  ////////////////////////////////////////////////////////////

  // Weights run on contiguously across row groups
  always_ff @(posedge clk) begin
    if (reset) begin
      weights_addr <= '0;
    end else if (conv_start) begin
      weights_addr <= weights_base;
    end else if (advance) begin
      weights_addr <= weights_addr + W_STEP;
    end
  end

  ////////////////////////////////////////////////////////////
  // Input address
  ////////////////////////////////////////////////////////////

  // Each group reads the same input chunks again
  always_ff @(posedge clk) begin
    if (reset) begin
      input_addr <= '0;
    end else if (conv_start || next_group) begin
      input_addr <= input_base;
    end else if (next_chunk) begin
      input_addr <= input_addr + I_STEP;
    end
  end

endmodule

`default_nettype wire

// ==== logic/conv_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_controller (
  input  logic clk,
  input  logic reset,
  input  logic conv_start,
  input  logic chunk_last,
  input  logic group_last,
  input  logic load_weights_fin,
  input  logic load_input_fin,
  input  logic compute_fin,
  input  logic store_fin,
  output logic load_weights,
  output logic load_input,
  output logic compute,
  output logic store,
  output logic next_chunk,
  output logic next_group,
  output logic busy,
  output logic layer_done
);

  conv_ctrl_pkg::ctrl_state_t state;
  conv_ctrl_pkg::ctrl_state_t state_next;
  logic                       adv;
  logic                       last_group_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= conv_ctrl_pkg::IDLE;
      adv          <= 1'b0;
      last_group_q <= 1'b0;
    end else begin
      state <= state_next;
      // Advance cycle follows the compute fin
      adv   <= (state == conv_ctrl_pkg::WAIT_C) && compute_fin;
      if (adv && chunk_last) begin
        // Group index moves on before the store, keep the old flag
        last_group_q <= group_last;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      conv_ctrl_pkg::IDLE: begin
        if (conv_start) begin
          state_next = conv_ctrl_pkg::LOAD_W;
        end
      end
      conv_ctrl_pkg::LOAD_W:  state_next = conv_ctrl_pkg::WAIT_W;
      conv_ctrl_pkg::WAIT_W: begin
        if (load_weights_fin) begin
          state_next = conv_ctrl_pkg::LOAD_I;
        end
      end
      conv_ctrl_pkg::LOAD_I:  state_next = conv_ctrl_pkg::WAIT_I;
      conv_ctrl_pkg::WAIT_I: begin
        if (load_input_fin) begin
          state_next = conv_ctrl_pkg::COMPUTE;
        end
      end
      conv_ctrl_pkg::COMPUTE: state_next = conv_ctrl_pkg::WAIT_C;
      conv_ctrl_pkg::WAIT_C: begin
        if (adv) begin
          state_next = chunk_last ? conv_ctrl_pkg::STORE : conv_ctrl_pkg::LOAD_W;
        end
      end
      conv_ctrl_pkg::STORE:   state_next = conv_ctrl_pkg::WAIT_S;
      conv_ctrl_pkg::WAIT_S: begin
        if (store_fin) begin
          state_next = last_group_q ? conv_ctrl_pkg::DONE : conv_ctrl_pkg::LOAD_W;
        end
      end
      conv_ctrl_pkg::DONE:    state_next = conv_ctrl_pkg::IDLE;
      default:                state_next = conv_ctrl_pkg::IDLE;
    endcase
  end

  // Unit pulses
  assign load_weights = (state == conv_ctrl_pkg::LOAD_W);
  assign load_input   = (state == conv_ctrl_pkg::LOAD_I);
  assign compute      = (state == conv_ctrl_pkg::COMPUTE);
  assign store        = (state == conv_ctrl_pkg::STORE);

  assign next_chunk = adv && !chunk_last;
  assign next_group = adv && chunk_last;

  assign busy       = (state != conv_ctrl_pkg::IDLE) && (state != conv_ctrl_pkg::DONE);
  assign layer_done = (state == conv_ctrl_pkg::DONE);

  a_one_start: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({load_weights, load_input, compute, store})
  ) else $error("conv_controller: more than one start pulse");

  a_wfin_in_wait: assert property (
    @(posedge clk) disable iff (reset)
    load_weights_fin |-> (state == conv_ctrl_pkg::WAIT_W)
  ) else $error("conv_controller: load_weights_fin outside WAIT_W");

  a_ifin_in_wait: assert property (
    @(posedge clk) disable iff (reset)
    load_input_fin |-> (state == conv_ctrl_pkg::WAIT_I)
  ) else $error("conv_controller: load_input_fin outside WAIT_I");

  a_cfin_in_wait: assert property (
    @(posedge clk) disable iff (reset)
    compute_fin |-> (state == conv_ctrl_pkg::WAIT_C) && !adv
  ) else $error("conv_controller: compute_fin outside WAIT_C");

  a_sfin_in_wait: assert property (
    @(posedge clk) disable iff (reset)
    store_fin |-> (state == conv_ctrl_pkg::WAIT_S)
  ) else $error("conv_controller: store_fin outside WAIT_S");

endmodule

`default_nettype wire

// ==== logic/conv_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              conv_decode,
  input  logic [conv_cfg_pkg::INSTR_W-1:0]  instr,
  input  logic                              load_weights_fin,
  input  logic                              load_input_fin,
  input  logic                              compute_fin,
  input  logic                              store_fin,
  output logic                              load_weights,
  output logic                              load_input,
  output logic                              compute,
  output logic                              store,
  output logic [conv_cfg_pkg::ADDR_W-1:0]   weights_addr,
  output logic [conv_cfg_pkg::ADDR_W-1:0]   input_addr,
  output logic [conv_ctrl_pkg::CHUNK_W-1:0] chunk_idx,
  output logic [conv_ctrl_pkg::GROUP_W-1:0] group_idx,
  output logic                              busy,
  output logic                              layer_done
);

  logic                              conv_start;
  logic [conv_ctrl_pkg::CHUNK_W-1:0] n_chunks;
  logic [conv_ctrl_pkg::GROUP_W-1:0] n_groups;
  logic [conv_cfg_pkg::ADDR_W-1:0]   weights_base;
  logic [conv_cfg_pkg::ADDR_W-1:0]   input_base;
  logic                              next_chunk;
  logic                              next_group;
  logic                              chunk_last;
  logic                              group_last;

  conv_decoder u_conv_decoder (
    .clk          (clk),
    .reset        (reset),
    .conv_decode  (conv_decode),
    .instr        (instr),
    .busy         (busy),
    .conv_start   (conv_start),
    .n_chunks     (n_chunks),
    .n_groups     (n_groups),
    .weights_base (weights_base),
    .input_base   (input_base)
  );

  conv_controller u_conv_controller (
    .clk              (clk),
    .reset            (reset),
    .conv_start       (conv_start),
    .chunk_last       (chunk_last),
    .group_last       (group_last),
    .load_weights_fin (load_weights_fin),
    .load_input_fin   (load_input_fin),
    .compute_fin      (compute_fin),
    .store_fin        (store_fin),
    .load_weights     (load_weights),
    .load_input       (load_input),
    .compute          (compute),
    .store            (store),
    .next_chunk       (next_chunk),
    .next_group       (next_group),
    .busy             (busy),
    .layer_done       (layer_done)
  );

  conv_loop_counter u_conv_loop_counter (
    .clk        (clk),
    .reset      (reset),
    .conv_start (conv_start),
    .next_chunk (next_chunk),
    .next_group (next_group),
    .n_chunks   (n_chunks),
    .n_groups   (n_groups),
    .chunk_idx  (chunk_idx),
    .group_idx  (group_idx),
    .chunk_last (chunk_last),
    .group_last (group_last)
  );

  conv_addr_gen u_conv_addr_gen (
    .clk          (clk),
    .reset        (reset),
    .conv_start   (conv_start),
    .next_chunk   (next_chunk),
    .next_group   (next_group),
    .weights_base (weights_base),
    .input_base   (input_base),
    .weights_addr (weights_addr),
    .input_addr   (input_addr)
  );

endmodule

`default_nettype wire

// ==== bench/conv_unit_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_unit_model #(
  parameter int unsigned SEED = 51965
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic fin
);

  int unsigned lcg_state;
  int unsigned delay;

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Start is looked at mid-cycle, fin is raised on a falling edge
  initial begin
    fin       = 1'b0;
    lcg_state = SEED;
    forever begin
      @(negedge clk);
      if (!reset && start) begin
        lcg_state = lcg_next(lcg_state);
        // 1 to 16 cycles of engine latency
        delay = ((lcg_state >> 16) & 32'hF) + 1;
        repeat (delay) @(negedge clk);
        fin = 1'b1;
        @(negedge clk);
        fin = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/conv_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;

  localparam int unsigned IW = conv_cfg_pkg::INSTR_W;
  localparam int unsigned AW = conv_cfg_pkg::ADDR_W;
  localparam int unsigned FW = conv_cfg_pkg::FEAT_W;
  localparam int unsigned KW = conv_cfg_pkg::KERNEL_W;
  localparam int unsigned CW = conv_ctrl_pkg::CHUNK_W;
  localparam int unsigned GW = conv_ctrl_pkg::GROUP_W;
  localparam int N_LAYERS = 3;

  // Shapes for 1x1, 2x3 and 3x2 groups by chunks
  localparam int unsigned OF_TAB [N_LAYERS] = '{8, 13, 17};
  localparam int unsigned NIF_TAB [N_LAYERS] = '{4, 20, 7};
  localparam int unsigned K_TAB [N_LAYERS] = '{3, 3, 4};
  localparam int unsigned WB_TAB [N_LAYERS] = '{32'h0100, 32'h1000, 32'h4400};
  localparam int unsigned IB_TAB [N_LAYERS] = '{32'h2000, 32'h3000, 32'h5080};

  logic          clk = 1'b0;
  logic          reset;
  logic          conv_decode;
  logic [IW-1:0] instr;
  logic          load_weights_fin;
  logic          load_input_fin;
  logic          compute_fin;
  logic          store_fin;
  logic          load_weights;
  logic          load_input;
  logic          compute;
  logic          store;
  logic [AW-1:0] weights_addr;
  logic [AW-1:0] input_addr;
  logic [CW-1:0] chunk_idx;
  logic [GW-1:0] group_idx;
  logic          busy;
  logic          layer_done;

  int unsigned   errors;
  int unsigned   n_pass;
  int unsigned   n_fail;
  int unsigned   cnt_lw;
  int unsigned   cnt_li;
  int unsigned   cnt_c;
  int unsigned   cnt_s;
  int unsigned   cur_groups;
  int unsigned   cur_chunks;
  logic [AW-1:0] cur_wbase;
  logic [AW-1:0] cur_ibase;
  string         cur_name;
  logic          clear_counts;
  logic          seen_decode;
  logic [CW-1:0] exp_chunk;
  logic [GW-1:0] exp_group;
  logic [AW-1:0] exp_waddr;
  logic [AW-1:0] exp_iaddr;
  logic          store_due;
  logic          layer_end;

  conv_ctrl_pkg::ctrl_state_t ctrl_state;

  always #2 clk = ~clk;

  conv_layer_top u_conv_layer_top (
    .clk              (clk),
    .reset            (reset),
    .conv_decode      (conv_decode),
    .instr            (instr),
    .load_weights_fin (load_weights_fin),
    .load_input_fin   (load_input_fin),
    .compute_fin      (compute_fin),
    .store_fin        (store_fin),
    .load_weights     (load_weights),
    .load_input       (load_input),
    .compute          (compute),
    .store            (store),
    .weights_addr     (weights_addr),
    .input_addr       (input_addr),
    .chunk_idx        (chunk_idx),
    .group_idx        (group_idx),
    .busy             (busy),
    .layer_done       (layer_done)
  );

  conv_unit_model #(.SEED(51965)) u_weights_loader (
    .clk(clk), .reset(reset), .start(load_weights), .fin(load_weights_fin)
  );
  conv_unit_model #(.SEED(51966)) u_input_loader (
    .clk(clk), .reset(reset), .start(load_input), .fin(load_input_fin)
  );
  conv_unit_model #(.SEED(51967)) u_compute_unit (
    .clk(clk), .reset(reset), .start(compute), .fin(compute_fin)
  );
  conv_unit_model #(.SEED(51968)) u_store_unit (
    .clk(clk), .reset(reset), .start(store), .fin(store_fin)
  );

  // Controller state held over the rising edge for error lines
  always @(negedge clk) begin
    ctrl_state <= u_conv_layer_top.u_conv_controller.state;
  end

  ////////////////////////////////////////////////////////////
  // Loop bounds and instruction packing
  ////////////////////////////////////////////////////////////

  function automatic int unsigned group_count(input int unsigned of_n);
    return (of_n + conv_cfg_pkg::PE_ROWS - 1) / conv_cfg_pkg::PE_ROWS;
  endfunction

  function automatic int unsigned chunk_count(input int unsigned nif_n, input int unsigned k_n);
    return (nif_n * k_n * k_n + conv_cfg_pkg::CHUNK_WORDS - 1) / conv_cfg_pkg::CHUNK_WORDS;
  endfunction

  function automatic logic [IW-1:0] make_instr(input int unsigned of_n, input int unsigned nif_n,
                                               input int unsigned k_n, input int unsigned wbase,
                                               input int unsigned ibase);
    logic [IW-1:0] w;
    w = '0;
    w[conv_cfg_pkg::OF_LSB +: FW]    = FW'(of_n);
    w[conv_cfg_pkg::NIF_LSB +: FW]   = FW'(nif_n);
    w[conv_cfg_pkg::K_LSB +: KW]     = KW'(k_n);
    w[conv_cfg_pkg::WBASE_LSB +: AW] = AW'(wbase);
    w[conv_cfg_pkg::IBASE_LSB +: AW] = AW'(ibase);
    return w;
  endfunction

  task automatic count_failure(input string what);
    errors = errors + 1;
    $display("Error: %s %s in state %s at %0t", cur_name, what, ctrl_state.name(), $time);
  endtask

  task automatic report_mismatch(input string what, input int unsigned expected,
                                 input int unsigned actual);
    errors = errors + 1;
    $display("** Error: %s %s expected %0d, actual %0d, state %s",
             cur_name, what, expected, actual, ctrl_state.name());
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset || clear_counts) begin
      cnt_lw <= 0;
      cnt_li <= 0;
      cnt_c  <= 0;
      cnt_s  <= 0;
    end else begin
      if (load_weights) cnt_lw <= cnt_lw + 1;
      if (load_input) cnt_li <= cnt_li + 1;
      if (compute) cnt_c <= cnt_c + 1;
      if (store) cnt_s <= cnt_s + 1;
    end
  end

  // Chunk and group position follow from the computes done so far
  always_comb begin
    exp_chunk = CW'(cnt_c % cur_chunks);
    exp_group = GW'(cnt_c / cur_chunks);
    exp_waddr = cur_wbase + AW'(cnt_lw * conv_cfg_pkg::WEIGHT_CHUNK_WORDS);
    exp_iaddr = cur_ibase + AW'((cnt_c % cur_chunks) * conv_cfg_pkg::INPUT_CHUNK_WORDS);
    store_due = (cnt_c != 0) && (cnt_c % cur_chunks == 0);
    layer_end = (cnt_s == cur_groups);
  end

  a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
    !seen_decode |-> !(load_weights || load_input || compute || store || busy || layer_done
      || u_conv_layer_top.conv_start) && (chunk_idx == '0) && (group_idx == '0))
    else count_failure("outputs not idle after reset");
  a_wfin_gap: assert property (@(posedge clk) disable iff (reset)
    load_weights_fin |=> load_input)
    else count_failure("load_input not one cycle after load_weights_fin");
  a_ifin_gap: assert property (@(posedge clk) disable iff (reset)
    load_input_fin |=> compute)
    else count_failure("compute not one cycle after load_input_fin");
  a_cfin_quiet: assert property (@(posedge clk) disable iff (reset)
    compute_fin |=> !(load_weights || load_input || compute || store))
    else count_failure("start pulse one cycle after compute_fin");
  a_cfin_next: assert property (@(posedge clk) disable iff (reset)
    $past(compute_fin, 2) |-> (store_due ? store : load_weights))
    else count_failure("wrong or missing pulse two cycles after compute_fin");
  a_input_order: assert property (@(posedge clk) disable iff (reset)
    load_input |-> $past(load_weights_fin))
    else count_failure("load_input without a load_weights_fin before it");
  a_compute_order: assert property (@(posedge clk) disable iff (reset)
    compute |-> $past(load_input_fin))
    else count_failure("compute without a load_input_fin before it");
  a_store_order: assert property (@(posedge clk) disable iff (reset)
    store |-> $past(compute_fin, 2) && store_due)
    else count_failure("store before the last chunk of the group");
  a_sfin_next: assert property (@(posedge clk) disable iff (reset)
    $past(store_fin) |-> (layer_end ? layer_done : load_weights))
    else count_failure("wrong or missing pulse one cycle after store_fin");
  a_done_after_sfin: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> $past(store_fin) && !busy)
    else count_failure("layer_done not one cycle after store_fin, or busy still high");
  a_restart_refused: assert property (@(posedge clk) disable iff (reset)
    busy && conv_decode |=> !u_conv_layer_top.conv_start)
    else count_failure("decode accepted while busy");

  a_weights_addr: assert property (@(posedge clk) disable iff (reset)
    load_weights |-> weights_addr == exp_waddr)
    else report_mismatch("weights_addr", int'($sampled(exp_waddr)), int'($sampled(weights_addr)));
  a_input_addr: assert property (@(posedge clk) disable iff (reset)
    load_input |-> input_addr == exp_iaddr)
    else report_mismatch("input_addr", int'($sampled(exp_iaddr)), int'($sampled(input_addr)));
  a_chunk_idx: assert property (@(posedge clk) disable iff (reset)
    (load_weights || load_input) |-> chunk_idx == exp_chunk)
    else report_mismatch("chunk_idx", int'($sampled(exp_chunk)), int'($sampled(chunk_idx)));
  a_group_idx: assert property (@(posedge clk) disable iff (reset)
    (load_weights || load_input) |-> group_idx == exp_group)
    else report_mismatch("group_idx", int'($sampled(exp_group)), int'($sampled(group_idx)));

  // Pulse totals per layer
  a_lw_count: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> cnt_lw == cur_groups * cur_chunks)
    else report_mismatch("load_weights count", cur_groups * cur_chunks, cnt_lw);
  a_li_count: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> cnt_li == cur_groups * cur_chunks)
    else report_mismatch("load_input count", cur_groups * cur_chunks, cnt_li);
  a_c_count: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> cnt_c == cur_groups * cur_chunks)
    else report_mismatch("compute count", cur_groups * cur_chunks, cnt_c);
  a_s_count: assert property (@(posedge clk) disable iff (reset)
    layer_done |-> cnt_s == cur_groups)
    else report_mismatch("store count", cur_groups, cnt_s);

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic run_layer(input int idx);
    int unsigned errs_before;
    int unsigned layer_errs;
    errs_before  = errors;
    cur_groups   = group_count(OF_TAB[idx]);
    cur_chunks   = chunk_count(NIF_TAB[idx], K_TAB[idx]);
    cur_wbase    = AW'(WB_TAB[idx]);
    cur_ibase    = AW'(IB_TAB[idx]);
    cur_name     = $sformatf("layer%0d_%0dx%0d", idx, cur_groups, cur_chunks);
    instr        = make_instr(OF_TAB[idx], NIF_TAB[idx], K_TAB[idx], WB_TAB[idx], IB_TAB[idx]);
    conv_decode  = 1'b1;
    clear_counts = 1'b1;
    seen_decode  = 1'b1;
    @(negedge clk);
    conv_decode  = 1'b0;
    clear_counts = 1'b0;
    // A second decode in mid layer
    do begin
      @(negedge clk);
    end while (!busy);
    instr       = make_instr(64, 100, 5, 32'h7000, 32'h7800);
    conv_decode = 1'b1;
    @(negedge clk);
    conv_decode = 1'b0;
    do begin
      @(negedge clk);
    end while (!layer_done);
    repeat (2) @(negedge clk);
    layer_errs = errors - errs_before;
    if (layer_errs == 0) begin
      n_pass = n_pass + 1;
    end else begin
      n_fail = n_fail + 1;
    end
    $display("%s %s (%0d errors)", cur_name, (layer_errs == 0) ? "passed" : "FAILED", layer_errs);
  endtask

  initial begin
    errors       = 0;
    n_pass       = 0;
    n_fail       = 0;
    cur_groups   = 1;
    cur_chunks   = 1;
    cur_wbase    = '0;
    cur_ibase    = '0;
    cur_name     = "reset";
    clear_counts = 1'b0;
    seen_decode  = 1'b0;
    reset        = 1'b1;
    conv_decode  = 1'b0;
    instr        = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Idle window after reset
    repeat (8) @(negedge clk);
    for (int i = 0; i < N_LAYERS; i++) begin
      run_layer(i);
    end
    $display("%0d layer tests: %0d passed, %0d failed, %0d errors",
             N_LAYERS, n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned limit;
    limit = 200;
    for (int i = 0; i < N_LAYERS; i++) begin
      limit = limit + group_count(OF_TAB[i]) * (chunk_count(NIF_TAB[i], K_TAB[i]) * 3 + 1) * 20;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: layers did not complete within %0d cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== conv_layer.f ====
logic/conv_cfg_pkg.sv
logic/conv_ctrl_pkg.sv
logic/conv_decoder.sv
logic/conv_loop_counter.sv
logic/conv_addr_gen.sv
logic/conv_controller.sv
logic/conv_layer_top.sv
bench/conv_unit_model.sv
bench/conv_layer_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vconv_layer_tb
SRCS := $(shell grep '\.sv$$' conv_layer.f)

.PHONY: all run clean

all: run

$(SIM): conv_layer.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module conv_layer_tb -f conv_layer.f

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir
